// ==== filelist.f ====
lru_pkg.sv
lru_dualport_ram.sv
lru_pseudo.sv
lru_tracker_top.sv
lru_tracker_assertions.sv
lru_tracker_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module lru_tracker_tb -f filelist.f

output=$(./obj_dir/Vlru_tracker_tb) || true
echo "$output"

if echo "$output" | grep -qx "TEST PASSED"; then
    exit 0
else
    exit 1
fi

// ==== lru_tracker_tb.sv ====
// Pseudo-LRU tracker testbench with clock, reset, stimulus, model, checks and watchdog
module lru_tracker_tb
    import lru_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 8;
    localparam int N_PORT0 = 60;
    localparam int N_PORT1 = 40;
    localparam int N_PAIRS = 20;
    localparam int N_STRESS = 500;

    // Two reset sweeps, three full lookup sweeps of three cycles per set, then the phases
    localparam int TEST_CYCLES = 2 * (RESET_CYCLES + LRU_SETS + 2) + 9 * LRU_SETS
        + 3 * N_PORT0 + 6 * N_PORT1 + 9 * N_PAIRS + N_STRESS + 16;
    localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;

    logic     clk;
    logic     reset;
    logic     rdy;
    set_idx_t lookup_idx;
    logic     lookup_en;
    way_vec_t lookup_vec;
    way_idx_t lookup_way;
    set_idx_t ref_idx0;
    way_vec_t ref_vec0;
    logic     ref_en0;
    set_idx_t ref_idx1;
    way_vec_t ref_vec1;
    logic     ref_en1;

    // Expected way bits of every set
    way_vec_t model [LRU_SETS];
    bit       passed;
    bit       fail_shown;

    lru_tracker_top i_dut
    (
        .clk       (clk),
        .reset     (reset),
        .rdy       (rdy),
        .lookup_idx(lookup_idx),
        .lookup_en (lookup_en),
        .lookup_vec(lookup_vec),
        .lookup_way(lookup_way),
        .ref_idx0  (ref_idx0),
        .ref_vec0  (ref_vec0),
        .ref_en0   (ref_en0),
        .ref_idx1  (ref_idx1),
        .ref_vec1  (ref_vec1),
        .ref_en1   (ref_en1)
    );

    // Concurrent checks are bound into the tracker core next to its RAM ports
    bind lru_pseudo lru_tracker_assert u_assert
    (
        .clk       (clk),
        .reset     (reset),
        .rdy       (rdy),
        .lookup_en (lookup_en),
        .lookup_vec(lookup_vec),
        .lookup_way(lookup_way),
        .addr0     (addr0),
        .wen0      (wen0),
        .addr1     (addr1),
        .wen1      (wen1)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ====================
    // Model
    // ====================

    // OR the reference in and start over once every way is marked
    function automatic way_vec_t apply_reference(input way_vec_t cur, input way_vec_t vec);
        way_vec_t result;
        result = cur | vec;
        if (result == {LRU_WAYS{1'b1}})
        begin
            result = '0;
        end
        return result;
    endfunction

    // Adding one carries through the low run of ones and lands on the lowest clear bit
    function automatic way_vec_t lowest_clear(input way_vec_t state);
        return ~state & (state + way_vec_t'(1));
    endfunction

    function automatic way_idx_t position_of(input way_vec_t onehot);
        way_idx_t pos;
        int       w;
        pos = '0;
        for (w = 0; w < LRU_WAYS; w++)
        begin
            if (onehot == (way_vec_t'(1) << w))
            begin
                pos = way_idx_t'(w);
            end
        end
        return pos;
    endfunction

    // ====================
    // Checks and phases
    // ====================

    task automatic stop_on_error(input string msg);
        $display("error at %0d ns: %s", $time, msg);
        fail_shown = 1'b1;
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // Pulse a lookup for one cycle and compare the response held in the next cycle
    task automatic check_lookup(input set_idx_t idx);
        way_vec_t exp_vec;
        way_idx_t exp_way;
        exp_vec = lowest_clear(model[idx]);
        exp_way = position_of(exp_vec);
        @(posedge clk);
        lookup_idx <= idx;
        lookup_en <= 1'b1;
        @(posedge clk);
        lookup_en <= 1'b0;
        @(negedge clk);
        assert (lookup_vec == exp_vec && lookup_way == exp_way)
        else stop_on_error($sformatf("set %0d gave vec %b way %0d, expected vec %b way %0d",
            idx, lookup_vec, lookup_way, exp_vec, exp_way));
    endtask

    task automatic check_all_sets();
        int i;
        for (i = 0; i < LRU_SETS; i++)
        begin
            check_lookup(set_idx_t'(i));
        end
    endtask

    // Starts on a rising edge
    // rdy stays low while reset is held and for the whole clearing sweep
    task automatic run_reset();
        int   i;
        logic exp_rdy;
        reset <= 1'b1;
        lookup_en <= 1'b0;
        ref_en0 <= 1'b0;
        ref_en1 <= 1'b0;
        @(posedge clk);
        for (i = 1; i < RESET_CYCLES; i++)
        begin
            @(negedge clk);
            assert (rdy == 1'b0)
            else stop_on_error($sformatf("rdy was %b during reset", rdy));
            @(posedge clk);
        end
        reset <= 1'b0;
        for (i = 0; i <= LRU_SETS; i++)
        begin
            exp_rdy = (i == LRU_SETS);
            @(negedge clk);
            assert (rdy == exp_rdy)
            else stop_on_error($sformatf("rdy was %b %0d cycles after reset release", rdy, i));
        end
        for (i = 0; i < LRU_SETS; i++)
        begin
            model[i] = '0;
        end
    endtask

    // Port 0 references every third cycle, which never hits the write cycle
    task automatic port0_references();
        int       n;
        set_idx_t idx;
        way_vec_t vec;
        for (n = 0; n < N_PORT0; n++)
        begin
            idx = set_idx_t'($urandom_range(15, 0));
            vec = way_vec_t'($urandom);
            @(posedge clk);
            ref_idx0 <= idx;
            ref_vec0 <= vec;
            ref_en0 <= 1'b1;
            model[idx] = apply_reference(model[idx], vec);
            @(posedge clk);
            ref_en0 <= 1'b0;
            @(posedge clk);
        end
    endtask

    // Port 1 references with a lookup behind each, after the write has landed
    task automatic port1_references();
        int       n;
        set_idx_t idx;
        way_vec_t vec;
        for (n = 0; n < N_PORT1; n++)
        begin
            idx = set_idx_t'($urandom_range(15, 0));
            vec = way_vec_t'($urandom);
            @(posedge clk);
            ref_idx1 <= idx;
            ref_vec1 <= vec;
            ref_en1 <= 1'b1;
            model[idx] = apply_reference(model[idx], vec);
            @(posedge clk);
            ref_en1 <= 1'b0;
            @(posedge clk);
            check_lookup(idx);
        end
    endtask

    // Both ports in the same cycle on two different sets
    task automatic paired_references();
        int       n;
        set_idx_t idx0;
        set_idx_t idx1;
        way_vec_t vec0;
        way_vec_t vec1;
        for (n = 0; n < N_PAIRS; n++)
        begin
            idx0 = set_idx_t'($urandom);
            idx1 = idx0 ^ set_idx_t'($urandom_range(LRU_SETS - 1, 1));
            vec0 = way_vec_t'($urandom);
            vec1 = way_vec_t'($urandom);
            @(posedge clk);
            ref_idx0 <= idx0;
            ref_vec0 <= vec0;
            ref_en0 <= 1'b1;
            ref_idx1 <= idx1;
            ref_vec1 <= vec1;
            ref_en1 <= 1'b1;
            model[idx0] = apply_reference(model[idx0], vec0);
            model[idx1] = apply_reference(model[idx1], vec1);
            @(posedge clk);
            ref_en0 <= 1'b0;
            ref_en1 <= 1'b0;
            @(posedge clk);
            check_lookup(idx0);
            check_lookup(idx1);
        end
    endtask

    // All ports at random
    // Dropped references leave the set state unknown so only the response shape is checked
    task automatic stress_all_ports();
        int   n;
        logic sampled;
        for (n = 0; n <= N_STRESS; n++)
        begin
            @(posedge clk);
            sampled = lookup_en;
            lookup_en <= (n < N_STRESS) && ($urandom_range(1, 0) != 0);
            lookup_idx <= set_idx_t'($urandom);
            ref_en0 <= (n < N_STRESS) && ($urandom_range(1, 0) != 0);
            ref_idx0 <= set_idx_t'($urandom);
            ref_vec0 <= way_vec_t'($urandom);
            ref_en1 <= (n < N_STRESS) && ($urandom_range(1, 0) != 0);
            ref_idx1 <= set_idx_t'($urandom);
            ref_vec1 <= way_vec_t'($urandom);
            @(negedge clk);
            if (sampled)
            begin
                assert ($onehot(lookup_vec) && lookup_vec == (way_vec_t'(1) << lookup_way))
                else stop_on_error($sformatf("stress lookup gave vec %b with way %0d",
                    lookup_vec, lookup_way));
            end
        end
        repeat (4) @(posedge clk);
    endtask

    // ====================
    // Main sequence
    // ====================

    initial
    begin
        void'($urandom(32'h628b_46ad));
        passed = 1'b0;
        fail_shown = 1'b0;
        reset = 1'b1;
        lookup_idx = '0;
        lookup_en = 1'b0;
        ref_idx0 = '0;
        ref_vec0 = '0;
        ref_en0 = 1'b0;
        ref_idx1 = '0;
        ref_vec1 = '0;
        ref_en1 = 1'b0;

        run_reset();
        check_all_sets();
        port0_references();
        check_all_sets();
        port1_references();
        paired_references();
        stress_all_ports();

        // The stress phase leaves the sets unknown and a second reset clears them again
        run_reset();
        check_all_sets();

        passed = 1'b1;
        $display("TEST PASSED");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_shown = 1'b1;
        $display("Watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $fatal(1, "Run stopped by the watchdog");
    end

    // End of simulation without a verdict from the main sequence
    final
    begin
        if (!passed && !fail_shown)
        begin
            $display("TEST FAILED");
        end
    end

endmodule

// ==== lru_tracker_assertions.sv ====
// Concurrent checks on the ready level, the lookup response and the RAM write ports
module lru_tracker_assert
    import lru_pkg::*;
(
    input logic     clk,
    input logic     reset,
    input logic     rdy,
    input logic     lookup_en,
    input way_vec_t lookup_vec,
    input way_idx_t lookup_way,
    input set_idx_t addr0,
    input logic     wen0,
    input set_idx_t addr1,
    input logic     wen1
);
    timeunit 1ns;
    timeprecision 1ps;

    // Once the sweep is over, only a reset brings rdy down
    rdy_holds: assert property (@(posedge clk) disable iff (reset) rdy |=> rdy)
        else $error("rdy fell while reset was low");

    // Port 1 holds its write back when port 0 writes the same set
    no_double_write: assert property (@(posedge clk) disable iff (reset)
        !(wen0 && wen1 && (addr0 == addr1)))
        else $error("both RAM ports wrote set %0d in the same cycle", addr0);

    // A set never holds all ones, so every answer names exactly one way
    lookup_onehot: assert property (@(posedge clk) disable iff (reset)
        (rdy && lookup_en) |=>
        ($onehot(lookup_vec) && (lookup_vec == (way_vec_t'(1) << lookup_way))))
        else $error("lookup answer %b does not match way %0d", lookup_vec, lookup_way);

endmodule

// ==== lru_tracker_top.sv ====
// Top level of the pseudo-LRU tracker, wiring its ports to the tracker core
module lru_tracker_top
    import lru_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    // Level ready, high after the set sweep that follows reset
    output logic     rdy,

    // Lookup request for one set
    input  set_idx_t lookup_idx,
    input  logic     lookup_en,

    // Lookup answer one cycle after the request
    output way_vec_t lookup_vec,
    output way_idx_t lookup_way,

    // Reference port 0
    input  set_idx_t ref_idx0,
    input  way_vec_t ref_vec0,
    input  logic     ref_en0,

    // Reference port 1, shares its RAM port with lookups
    input  set_idx_t ref_idx1,
    input  way_vec_t ref_vec1,
    input  logic     ref_en1
);

    // ====================
    // Tracker core
    // ====================

    // Every port maps one to one onto the core
    lru_pseudo u_lru
    (
        .clk       (clk),
        .reset     (reset),
        .rdy       (rdy),
        .lookup_idx(lookup_idx),
        .lookup_en (lookup_en),
        .lookup_vec(lookup_vec),
        .lookup_way(lookup_way),
        .ref_idx0  (ref_idx0),
        .ref_vec0  (ref_vec0),
        .ref_en0   (ref_en0),
        .ref_idx1  (ref_idx1),
        .ref_vec1  (ref_vec1),
        .ref_en1   (ref_en1)
    );

endmodule

// ==== lru_pseudo.sv ====
// Pseudo-LRU tracker with set initialization, two reference pipelines and lookup encoder
module lru_pseudo
    import lru_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    // High once every set has been cleared, stays high until the next reset
    output logic     rdy,

    // Lookup request, answered in the following cycle only
    input  set_idx_t lookup_idx,
    input  logic     lookup_en,

    // Lookup response as a one-hot vector and as a way number
    output way_vec_t lookup_vec,
    output way_idx_t lookup_way,

    // Reference port 0, the way vector is ORed into the set
    input  set_idx_t ref_idx0,
    input  way_vec_t ref_vec0,
    input  logic     ref_en0,

    // Reference port 1, yields to lookups
    input  set_idx_t ref_idx1,
    input  way_vec_t ref_vec1,
    input  logic     ref_en1
);

    // OR a reference into the set state and clear the set once all ways are marked
    function automatic way_vec_t lru_update(input way_vec_t cur, input way_vec_t ref_vec);
        way_vec_t merged;
        merged = cur | ref_vec;
        return (&merged) ? way_vec_t'(0) : merged;
    endfunction

    // ====================
    // Storage
    // ====================

    set_idx_t addr0;
    logic     wen0;
    way_vec_t wdata0;
    way_vec_t rdata0;

    set_idx_t addr1;
    logic     wen1;
    way_vec_t wdata1;
    way_vec_t rdata1;

    // One word of way bits per set
    lru_dualport_ram
    #(
        .n_entries  (LRU_SETS),
        .n_data_bits($bits(way_vec_t))
    )
    u_ram
    (
        .clk   (clk),
        .addr0 (addr0),
        .wen0  (wen0),
        .wdata0(wdata0),
        .rdata0(rdata0),
        .addr1 (addr1),
        .wen1  (wen1),
        .wdata1(wdata1),
        .rdata1(rdata1)
    );

    // ====================
    // Initialization
    // ====================

    // One extra bit so the top bit flags the end of the sweep
    logic [$bits(set_idx_t):0] init_cnt;
    logic                      init_done;

    assign init_done = init_cnt[$bits(set_idx_t)];
    assign rdy = init_done;

    // Walks through every set once, one set per cycle, on port 0
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            init_cnt <= '0;
        end
        else if (!init_done)
        begin
            init_cnt <= init_cnt + 1'b1;
        end
    end

    // ====================
    // Port 0 pipeline
    // ====================

    // Stage 1 reads the set, stage 2 registers the read data, stage 3 writes
    logic     upd0_en;
    logic     upd0_en_q;
    logic     upd0_en_qq;
    set_idx_t upd0_idx_q;
    set_idx_t upd0_idx_qq;
    way_vec_t upd0_vec_q;
    way_vec_t upd0_vec_qq;
    way_vec_t upd0_cur_qq;

    // Port 0 is owned by initialization first, then by a pending write
    always_comb
    begin
        addr0 = ref_idx0;
        wdata0 = lru_update(upd0_cur_qq, upd0_vec_qq);
        wen0 = 1'b0;
        upd0_en = ref_en0;

        if (!init_done)
        begin
            // The sweep starts writing in the first cycle with reset low
            addr0 = init_cnt[$bits(set_idx_t)-1:0];
            wdata0 = '0;
            wen0 = !reset;
            upd0_en = 1'b0;
        end
        else if (upd0_en_qq)
        begin
            // The port is busy writing, so a reference arriving now is dropped
            addr0 = upd0_idx_qq;
            wen0 = 1'b1;
            upd0_en = 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            upd0_en_q <= 1'b0;
            upd0_en_qq <= 1'b0;
        end
        else
        begin
            upd0_en_q <= upd0_en;
            upd0_en_qq <= upd0_en_q;
        end
    end

    // Address, way vector and read data travel beside the valid bits
    always_ff @(posedge clk)
    begin
        upd0_idx_q <= ref_idx0;
        upd0_vec_q <= ref_vec0;
        upd0_idx_qq <= upd0_idx_q;
        upd0_vec_qq <= upd0_vec_q;
        // Read data here belongs to the read issued one cycle earlier
        upd0_cur_qq <= rdata0;
    end

    // ====================
    // Port 1 pipeline
    // ====================

    logic     upd1_en;
    logic     upd1_en_q;
    logic     upd1_en_qq;
    set_idx_t upd1_idx_q;
    set_idx_t upd1_idx_qq;
    way_vec_t upd1_vec_q;
    way_vec_t upd1_vec_qq;
    way_vec_t upd1_cur_qq;

    // A new reference needs the read slot, which lookups and pending writes take
    assign upd1_en = ref_en1 && init_done && !lookup_en && !upd1_en_qq;

    // Lookups win the port, then a pending write, then a new reference read
    always_comb
    begin
        addr1 = ref_idx1;
        if (lookup_en)
        begin
            addr1 = lookup_idx;
        end
        else if (upd1_en_qq)
        begin
            addr1 = upd1_idx_qq;
        end
    end

    assign wdata1 = lru_update(upd1_cur_qq, upd1_vec_qq);

    // The write also waits while port 0 writes the same set
    assign wen1 = upd1_en_qq && !lookup_en && !(wen0 && (addr0 == upd1_idx_qq));

    // The last stage holds its write until a free cycle comes along
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            upd1_en_q <= 1'b0;
            upd1_en_qq <= 1'b0;
        end
        else
        begin
            upd1_en_q <= upd1_en;
            if (upd1_en_q)
            begin
                upd1_en_qq <= 1'b1;
            end
            else if (wen1)
            begin
                upd1_en_qq <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        upd1_idx_q <= ref_idx1;
        upd1_vec_q <= ref_vec1;
        // Only a read for update moves into the write stage
        if (upd1_en_q)
        begin
            upd1_idx_qq <= upd1_idx_q;
            upd1_vec_qq <= upd1_vec_q;
            upd1_cur_qq <= rdata1;
        end
    end

    // ====================
    // Lookup response
    // ====================

    // Lowest clear way bit of the port 1 read data
    // The update rule never leaves a set with all bits high
    always_comb
    begin
        logic found;
        found = 1'b0;
        lookup_vec = '0;
        lookup_way = '0;
        for (int w = 0; w < LRU_WAYS; w++)
        begin
            if (!found && !rdata1[w])
            begin
                lookup_vec[w] = 1'b1;
                lookup_way = way_idx_t'(w);
                found = 1'b1;
            end
        end
    end

endmodule

// ==== lru_dualport_ram.sv ====
// Generic two-port RAM with registered read data and read-before-write ports
module lru_dualport_ram
#(
    parameter int n_entries = 64,
    parameter int n_data_bits = 4
)
(
    input  logic                         clk,

    // Port 0 address, write enable, write data and read data
    input  logic [$clog2(n_entries)-1:0] addr0,
    input  logic                         wen0,
    input  logic [n_data_bits-1:0]       wdata0,
    output logic [n_data_bits-1:0]       rdata0,

    // Port 1 address, write enable, write data and read data
    input  logic [$clog2(n_entries)-1:0] addr1,
    input  logic                         wen1,
    input  logic [n_data_bits-1:0]       wdata1,
    output logic [n_data_bits-1:0]       rdata1
);

    // Storage array, one word per entry
    logic [n_data_bits-1:0] mem [n_entries];

    // Both ports share the clock
    // Read data is the word from before any write in the same cycle
    always_ff @(posedge clk)
    begin
        rdata0 <= mem[addr0];
        rdata1 <= mem[addr1];

        // The user keeps the two ports off the same address when both write
        if (wen0)
        begin
            mem[addr0] <= wdata0;
        end
        if (wen1)
        begin
            mem[addr1] <= wdata1;
        end
    end

endmodule

// ==== lru_pkg.sv ====
// Set and way constants, index and way vector types for the pseudo-LRU tracker
package lru_pkg;

    // ====================
    // Geometry
    // ====================

    // Ways per set in the cache served by the tracker
    localparam int LRU_WAYS = 4;

    // Number of sets, kept a power of two so the index has no unused codes
    localparam int LRU_SETS = 64;

    // ====================
    // Types
    // ====================

    // Index of one set in the tracker RAM
    typedef logic [$clog2(LRU_SETS)-1:0] set_idx_t;

    // One bit per way, a set bit marks a recently referenced way
    typedef logic [LRU_WAYS-1:0] way_vec_t;

    // Number of a single way, as returned by a lookup
    typedef logic [$clog2(LRU_WAYS)-1:0] way_idx_t;

endpackage
